//--- src/vdp_cmd_pkg.sv
// Command engine package with shared types, opcodes and request structs

package vdp_cmd_pkg;

  // Coordinates and pixel counts
  typedef logic [9:0] coord_t;

  // Colour value or one VRAM byte
  typedef logic [7:0] color_t;

  // Byte address into the 128 KiB VRAM
  typedef logic [16:0] vram_addr_t;

  // CPU register index, 0..11 coordinates, 12 CLR, 13 ARG, 14 CMR
  typedef logic [3:0] reg_num_t;

  // Upper CMR nibble
  typedef enum logic [3:0] {
    STOP  = 4'd0,
    POINT = 4'd4,
    PSET  = 4'd5,
    LMMV  = 4'd8,
    HMMV  = 4'd12
  } cmd_op_t;

  // Lower CMR bits, destination = op(source, destination)
  typedef enum logic [2:0] {
    IMP = 3'd0,
    AND = 3'd1,
    OR  = 3'd2,
    EOR = 3'd3,
    NOT = 3'd4
  } logic_op_t;

  // G4 packs two pixels per byte, G7 one
  typedef enum logic {
    MODE_G4 = 1'b0,
    MODE_G7 = 1'b1
  } screen_mode_t;

  // Full command register bank as seen by the sequencer
  typedef struct packed {
    coord_t    sx;
    coord_t    sy;
    coord_t    dx;
    coord_t    dy;
    coord_t    nx;
    coord_t    ny;
    color_t    clr;
    logic      dix;
    logic      diy;
    cmd_op_t   cmd;
    logic      transparent;
    logic_op_t lop;
  } cmd_regs_t;

  // One VRAM access, write when we is set
  typedef struct packed {
    vram_addr_t addr;
    color_t     wdata;
    logic       we;
  } vram_req_t;

  // X bit that flags the right edge (x == 256) or a wrap below zero
  localparam int X_LIMIT_BIT = 8;

endpackage

//--- src/vdp_cmd_regs.sv
// Command register bank, CPU toggle handshake and command start pulse

`timescale 1ns/1ps

module vdp_cmd_regs import vdp_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      reg_wr_req,
  input  reg_num_t  reg_num,
  input  color_t    reg_data,
  input  logic      clr_load,
  input  color_t    clr_value,
  output logic      reg_wr_ack,
  output cmd_regs_t regs,
  output logic      cmd_start
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      regs       <= '0;
      cmd_start  <= 1'b0;
    end else begin
      cmd_start <= 1'b0;
      // POINT result lands in CLR, a CPU write to CLR below still wins
      if (clr_load) begin
        regs.clr <= clr_value;
      end
      // Pending while the toggles differ
      if (reg_wr_req != reg_wr_ack) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          4'd0:  regs.sx[7:0] <= reg_data;
          4'd1:  regs.sx[9:8] <= reg_data[1:0];
          4'd2:  regs.sy[7:0] <= reg_data;
          4'd3:  regs.sy[9:8] <= reg_data[1:0];
          4'd4:  regs.dx[7:0] <= reg_data;
          4'd5:  regs.dx[9:8] <= reg_data[1:0];
          4'd6:  regs.dy[7:0] <= reg_data;
          4'd7:  regs.dy[9:8] <= reg_data[1:0];
          4'd8:  regs.nx[7:0] <= reg_data;
          4'd9:  regs.nx[9:8] <= reg_data[1:0];
          4'd10: regs.ny[7:0] <= reg_data;
          4'd11: regs.ny[9:8] <= reg_data[1:0];
          4'd12: regs.clr     <= reg_data;
          // ARG, direction bits only
          4'd13: begin
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          // CMR, starts or aborts a command
          4'd14: begin
            regs.cmd         <= cmd_op_t'(reg_data[7:4]);
            regs.transparent <= reg_data[3];
            regs.lop         <= logic_op_t'(reg_data[2:0]);
            cmd_start        <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Ack moves only in answer to a pending request
  assert property (@(posedge clk) disable iff (reset)
    (reg_wr_ack != $past(reg_wr_ack)) |-> $past(reg_wr_req != reg_wr_ack));

endmodule

//--- src/vdp_pixel_unit.sv
// Pixel unit extracting the addressed pixel, applying the logical op and merging the byte

`timescale 1ns/1ps

module vdp_pixel_unit import vdp_cmd_pkg::*; (
  input  screen_mode_t mode,
  input  logic         x_low,
  input  color_t       rdata,
  input  color_t       src,
  input  logic_op_t    lop,
  input  logic         transparent,
  output color_t       point,
  output color_t       wbyte
);

  color_t col_mask;
  color_t src_m;
  color_t result;

  // Addressed pixel out of the byte just read
  always_comb begin
    if (mode == MODE_G4) begin
      col_mask = 8'h0f;
      // Even X in the high nibble
      point = x_low ? {4'h0, rdata[3:0]} : {4'h0, rdata[7:4]};
    end else begin
      col_mask = 8'hff;
      point    = rdata;
    end
  end

  assign src_m = src & col_mask;

  // Logical operation, transparent zero keeps the old pixel
  always_comb begin
    if (transparent && (src_m == 8'h00)) begin
      result = point;
    end else begin
      case (lop)
        IMP:     result = src_m;
        AND:     result = src_m & point;
        OR:      result = src_m | point;
        EOR:     result = src_m ^ point;
        NOT:     result = ~src_m;
        default: result = point;
      endcase
    end
  end

  // Merge back, other nibble untouched
  always_comb begin
    if (mode == MODE_G4) begin
      if (x_low) begin
        wbyte = {rdata[7:4], result[3:0]};
      end else begin
        wbyte = {result[3:0], rdata[3:0]};
      end
    end else begin
      wbyte = result;
    end
  end

endmodule

//--- src/vdp_cmd_sequencer.sv
// Command sequencer FSM stepping X/Y and driving the VRAM toggle handshake

`timescale 1ns/1ps

module vdp_cmd_sequencer import vdp_cmd_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  screen_mode_t mode,
  input  cmd_regs_t    regs,
  input  logic         cmd_start,
  input  logic         vram_ack_tgl,
  input  color_t       vram_rdata,
  input  color_t       point,
  input  color_t       wbyte,
  output vram_req_t    vram_req,
  output logic         vram_req_tgl,
  output logic         x_low,
  output logic         ce,
  output logic         clr_load,
  output color_t       clr_value
);

  typedef enum logic [3:0] {
    IDLE, CHK_LOOP, PRE_RD, WAIT_PRE_RD, RD_PT, WAIT_RD_PT, WR, WAIT_WR, EXEC_END
  } cmd_state_t;

  cmd_state_t state;
  coord_t     dx_cnt;
  coord_t     dy_cnt;
  coord_t     nx_cnt;
  coord_t     ny_cnt;
  coord_t     dx_org;
  coord_t     nx_org;
  logic       first_step;
  logic       idle_bus;
  logic       byte_mode;
  logic       row_end;
  logic       last_row;
  coord_t     x_step;
  coord_t     y_step;
  coord_t     start_x;
  coord_t     start_y;
  coord_t     nx_init;
  vram_addr_t addr;

  // No request outstanding
  assign idle_bus = (vram_req_tgl == vram_ack_tgl);

  // HMMV in G4 moves whole bytes of two pixels
  assign byte_mode = (regs.cmd == HMMV) && (mode == MODE_G4);
  assign x_step    = byte_mode ? (regs.dix ? 10'h3fe : 10'h002) : (regs.dix ? 10'h3ff : 10'h001);
  assign y_step    = regs.diy ? 10'h3ff : 10'h001;
  assign nx_init   = byte_mode ? {1'b0, regs.nx[9:1]} : regs.nx;

  // POINT reads at SX/SY while the rest draws at DX/DY
  assign start_x = (regs.cmd == POINT) ? regs.sx : regs.dx;
  assign start_y = (regs.cmd == POINT) ? regs.sy : regs.dy;

  // Row ends on count or edge and the command on NY or top edge
  assign row_end  = (nx_cnt == 10'd0) || dx_cnt[X_LIMIT_BIT];
  assign last_row = (ny_cnt == 10'd1) || (regs.diy && (dy_cnt == 10'd0));

  assign addr  = (mode == MODE_G4) ? {dy_cnt, dx_cnt[7:1]} : {dy_cnt[8:0], dx_cnt[7:0]};
  assign x_low = dx_cnt[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= IDLE;
      dx_cnt       <= '0;
      dy_cnt       <= '0;
      nx_cnt       <= '0;
      ny_cnt       <= '0;
      dx_org       <= '0;
      nx_org       <= '0;
      first_step   <= 1'b0;
      vram_req     <= '0;
      vram_req_tgl <= 1'b0;
      ce           <= 1'b0;
      clr_load     <= 1'b0;
      clr_value    <= '0;
    end else begin
      clr_load <= 1'b0;
      if (cmd_start) begin
        // CMR write restarts the command or STOP aborts it
        if (regs.cmd == STOP) begin
          ce    <= 1'b0;
          state <= IDLE;
        end else begin
          dx_cnt     <= start_x;
          dx_org     <= start_x;
          dy_cnt     <= start_y;
          nx_cnt     <= nx_init;
          nx_org     <= nx_init;
          ny_cnt     <= regs.ny;
          first_step <= 1'b1;
          state      <= CHK_LOOP;
        end
      end else begin
        case (state)
          IDLE: ;
          CHK_LOOP: begin
            first_step <= 1'b0;
            if (!first_step && row_end && last_row) begin
              ce    <= 1'b0;
              state <= EXEC_END;
            end else begin
              ce <= 1'b1;
              // Next row from the saved start column
              if (!first_step && row_end) begin
                dx_cnt <= dx_org;
                nx_cnt <= nx_org;
                ny_cnt <= ny_cnt - 10'd1;
                dy_cnt <= dy_cnt + y_step;
              end
              case (regs.cmd)
                HMMV:       state <= WR;
                LMMV, PSET: state <= PRE_RD;
                POINT:      state <= RD_PT;
                default: begin
                  ce    <= 1'b0;
                  state <= EXEC_END;
                end
              endcase
            end
          end
          // Reads wait out any request left over from an abort
          PRE_RD, RD_PT: begin
            if (idle_bus) begin
              vram_req.addr <= addr;
              vram_req.we   <= 1'b0;
              vram_req_tgl  <= ~vram_req_tgl;
              state         <= (state == PRE_RD) ? WAIT_PRE_RD : WAIT_RD_PT;
            end
          end
          WAIT_PRE_RD: begin
            if (idle_bus) begin
              vram_req.wdata <= wbyte;
              state          <= WR;
            end
          end
          WAIT_RD_PT: begin
            if (idle_bus) begin
              clr_value <= point;
              clr_load  <= 1'b1;
              ce        <= 1'b0;
              state     <= EXEC_END;
            end
          end
          WR: begin
            if (idle_bus) begin
              vram_req.addr  <= addr;
              vram_req.wdata <= (regs.cmd == HMMV) ? regs.clr : vram_req.wdata;
              vram_req.we    <= 1'b1;
              vram_req_tgl   <= ~vram_req_tgl;
              state          <= WAIT_WR;
            end
          end
          WAIT_WR: begin
            if (idle_bus) begin
              if (regs.cmd == PSET) begin
                ce    <= 1'b0;
                state <= EXEC_END;
              end else begin
                dx_cnt <= dx_cnt + x_step;
                nx_cnt <= nx_cnt - 10'd1;
                state  <= CHK_LOOP;
              end
            end
          end
          default: begin
            ce    <= 1'b0;
            state <= IDLE;
          end
        endcase
      end
    end
  end

  // No new request while one is outstanding
  assert property (@(posedge clk) disable iff (reset)
    (vram_req_tgl != $past(vram_req_tgl)) |-> $past(vram_req_tgl == vram_ack_tgl));

  // Busy flag tracks the FSM leaving IDLE
  assert property (@(posedge clk) disable iff (reset)
    (state == IDLE) |-> !ce);

endmodule

//--- src/vdp_command.sv
// Bitmap command engine top with register bank, sequencer and pixel unit

`timescale 1ns/1ps

module vdp_command import vdp_cmd_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  screen_mode_t mode,
  input  logic         reg_wr_req,
  input  reg_num_t     reg_num,
  input  color_t       reg_data,
  input  logic         vram_ack_tgl,
  input  color_t       vram_rdata,
  output logic         reg_wr_ack,
  output vram_req_t    vram_req,
  output logic         vram_req_tgl,
  output logic         ce,
  output color_t       clr
);

  cmd_regs_t regs;
  logic      cmd_start;
  logic      clr_load;
  color_t    clr_value;
  logic      x_low;
  color_t    point;
  color_t    wbyte;

  // CPU side registers
  vdp_cmd_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .clr_load   (clr_load),
    .clr_value  (clr_value),
    .reg_wr_ack (reg_wr_ack),
    .regs       (regs),
    .cmd_start  (cmd_start)
  );

  // Drawing FSM and VRAM master
  vdp_cmd_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .regs         (regs),
    .cmd_start    (cmd_start),
    .vram_ack_tgl (vram_ack_tgl),
    .vram_rdata   (vram_rdata),
    .point        (point),
    .wbyte        (wbyte),
    .vram_req     (vram_req),
    .vram_req_tgl (vram_req_tgl),
    .x_low        (x_low),
    .ce           (ce),
    .clr_load     (clr_load),
    .clr_value    (clr_value)
  );

  // Read-modify-write datapath
  vdp_pixel_unit u_pixel_unit (
    .mode        (mode),
    .x_low       (x_low),
    .rdata       (vram_rdata),
    .src         (regs.clr),
    .lop         (regs.lop),
    .transparent (regs.transparent),
    .point       (point),
    .wbyte       (wbyte)
  );

  assign clr = regs.clr;

endmodule

//--- bench/vdp_command_checker.sv
// Bus monitor and scoreboard comparing every VRAM access with a reference model

`timescale 1ns/1ps

module vdp_command_checker import vdp_cmd_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  screen_mode_t mode,
  input  logic         reg_wr_ack,
  input  reg_num_t     reg_num,
  input  color_t       reg_data,
  input  vram_req_t    vram_req,
  input  logic         vram_req_tgl,
  input  logic         vram_ack_tgl,
  input  color_t       vram_rdata,
  input  logic         ce,
  input  color_t       clr,
  output int           errors,
  output int           checks
);

  coord_t     sh_sx, sh_sy, sh_dx, sh_dy, sh_nx, sh_ny;
  color_t     sh_clr;
  color_t     sh_cmr;
  logic       sh_dix, sh_diy;
  coord_t     exp_x[$];
  coord_t     exp_y[$];
  logic       prev_req, prev_ack, prev_reg_ack, prev_ce, prev_rst;
  logic       stopping, clr_check;
  int         stop_cycles;
  color_t     last_rd, exp_point, exp_d;
  vram_addr_t exp_a;
  coord_t     cx, cy;

  // G4 uses Y then X[7:1] and G7 uses Y[8:0] then X[7:0]
  function automatic vram_addr_t ref_addr(screen_mode_t m, coord_t x, coord_t y);
    if (m == MODE_G4) ref_addr = {y, x[7:1]};
    else ref_addr = {y[8:0], x[7:0]};
  endfunction

  // Even X sits in the high nibble
  function automatic color_t ref_pixel(screen_mode_t m, logic xl, color_t rd);
    if (m == MODE_G7) ref_pixel = rd;
    else ref_pixel = xl ? {4'h0, rd[3:0]} : {4'h0, rd[7:4]};
  endfunction

  function automatic color_t ref_merge(screen_mode_t m, logic xl, color_t rd, color_t src,
                                       logic [2:0] op, logic tr);
    color_t pix;
    color_t s;
    color_t r;
    pix = ref_pixel(m, xl, rd);
    s = (m == MODE_G4) ? {4'h0, src[3:0]} : src;
    case (op)
      3'd0: r = s;
      3'd1: r = s & pix;
      3'd2: r = s | pix;
      3'd3: r = s ^ pix;
      3'd4: r = ~s;
      default: r = pix;
    endcase
    // Transparent zero source leaves the pixel
    if (tr && s == 8'h00) r = pix;
    if (m == MODE_G7) ref_merge = r;
    else ref_merge = xl ? {rd[7:4], r[3:0]} : {r[3:0], rd[3:0]};
  endfunction

  // Expected pixel positions of the whole command in drawing order
  task automatic build_list();
    coord_t x, y, cnt, cnt0, ny, xs, ys;
    logic   first, bytew;
    exp_x.delete();
    exp_y.delete();
    if (sh_cmr[7:4] == 4'd4) begin
      // POINT has a single read at SX/SY
      exp_x.push_back(sh_sx);
      exp_y.push_back(sh_sy);
    end else if (sh_cmr[7:4] == 4'd5) begin
      exp_x.push_back(sh_dx);
      exp_y.push_back(sh_dy);
    end else if (sh_cmr[7:4] == 4'd8 || sh_cmr[7:4] == 4'd12) begin
      bytew = (sh_cmr[7:4] == 4'd12) && (mode == MODE_G4);
      xs = bytew ? 10'd2 : 10'd1;
      if (sh_dix) xs = 10'd0 - xs;
      ys = sh_diy ? 10'h3ff : 10'd1;
      cnt0 = bytew ? {1'b0, sh_nx[9:1]} : sh_nx;
      x = sh_dx;
      y = sh_dy;
      cnt = cnt0;
      ny = sh_ny;
      forever begin
        first = 1'b1;
        // First pixel of a row is always drawn
        while (first || (cnt != 10'd0 && !x[8])) begin
          exp_x.push_back(x);
          exp_y.push_back(y);
          x = x + xs;
          cnt = cnt - 10'd1;
          first = 1'b0;
        end
        if (ny == 10'd1 || (sh_diy && y == 10'd0)) break;
        x = sh_dx;
        cnt = cnt0;
        ny = ny - 10'd1;
        y = y + ys;
      end
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      errors = 0;
      checks = 0;
      {sh_sx, sh_sy, sh_dx, sh_dy, sh_nx, sh_ny} = '0;
      {sh_clr, sh_cmr, sh_dix, sh_diy} = '0;
      {prev_req, prev_ack, prev_reg_ack, prev_ce} = '0;
      {stopping, clr_check} = '0;
      prev_rst = 1'b1;
      stop_cycles = 0;
      last_rd = '0;
      exp_point = '0;
    end else begin
      // Idle outputs right after reset
      if (prev_rst) begin
        checks++;
        if (ce !== 1'b0 || vram_req_tgl !== 1'b0 || reg_wr_ack !== 1'b0 ||
            clr !== 8'h00) begin
          $display("error at %0t: outputs not idle after reset", $time);
          errors++;
        end
      end
      // New VRAM request
      if (vram_req_tgl != prev_req) begin
        checks++;
        if (prev_req != prev_ack) begin
          $display("error at %0t: request issued while one was outstanding", $time);
          errors++;
        end
        if (stopping) begin
          $display("error at %0t: request issued after STOP", $time);
          errors++;
        end else if (vram_req.we) begin
          if (exp_x.size() == 0 || sh_cmr[7:4] == 4'd4) begin
            $display("error at %0t: unexpected write to %h", $time, vram_req.addr);
            errors++;
          end else begin
            cx = exp_x.pop_front();
            cy = exp_y.pop_front();
            exp_a = ref_addr(mode, cx, cy);
            if (sh_cmr[7:4] == 4'd12) exp_d = sh_clr;
            else exp_d = ref_merge(mode, cx[0], last_rd, sh_clr, sh_cmr[2:0], sh_cmr[3]);
            if (vram_req.addr != exp_a || vram_req.wdata != exp_d) begin
              $display("error at %0t: write %h=%h, expected %h=%h", $time,
                       vram_req.addr, vram_req.wdata, exp_a, exp_d);
              errors++;
            end
          end
        end else begin
          if (exp_x.size() == 0 || sh_cmr[7:4] == 4'd12) begin
            $display("error at %0t: unexpected read of %h", $time, vram_req.addr);
            errors++;
          end else begin
            exp_a = ref_addr(mode, exp_x[0], exp_y[0]);
            // POINT uses up its only entry with the read
            if (sh_cmr[7:4] == 4'd4) begin
              cx = exp_x.pop_front();
              cy = exp_y.pop_front();
            end
            if (vram_req.addr != exp_a) begin
              $display("error at %0t: read %h, expected %h", $time, vram_req.addr, exp_a);
              errors++;
            end
          end
        end
      end
      // Read data valid when the toggles meet
      if (vram_ack_tgl != prev_ack && !vram_req.we) begin
        last_rd = vram_rdata;
        exp_point = ref_pixel(mode, sh_sx[0], vram_rdata);
      end
      if (clr_check) begin
        clr_check = 1'b0;
        checks++;
        if (clr != exp_point) begin
          $display("error at %0t: POINT gave clr %h, expected %h", $time, clr, exp_point);
          errors++;
        end
        sh_clr = exp_point;
      end
      // End of command
      if (prev_ce && !ce && !stopping) begin
        checks++;
        if (exp_x.size() != 0) begin
          $display("error at %0t: %0d accesses missing", $time, exp_x.size());
          errors++;
        end
        if (sh_cmr[7:4] == 4'd4) clr_check = 1'b1;
      end
      if (stopping && ce) begin
        stop_cycles++;
        if (stop_cycles == 4) begin
          $display("error at %0t: ce still high after STOP", $time);
          errors++;
        end
      end
      // Register write acknowledged
      if (reg_wr_ack != prev_reg_ack) begin
        case (reg_num)
          4'd0: sh_sx[7:0] = reg_data;
          4'd1: sh_sx[9:8] = reg_data[1:0];
          4'd2: sh_sy[7:0] = reg_data;
          4'd3: sh_sy[9:8] = reg_data[1:0];
          4'd4: sh_dx[7:0] = reg_data;
          4'd5: sh_dx[9:8] = reg_data[1:0];
          4'd6: sh_dy[7:0] = reg_data;
          4'd7: sh_dy[9:8] = reg_data[1:0];
          4'd8: sh_nx[7:0] = reg_data;
          4'd9: sh_nx[9:8] = reg_data[1:0];
          4'd10: sh_ny[7:0] = reg_data;
          4'd11: sh_ny[9:8] = reg_data[1:0];
          4'd12: sh_clr = reg_data;
          4'd13: {sh_diy, sh_dix} = reg_data[3:2];
          4'd14: begin
            sh_cmr = reg_data;
            stopping = (reg_data[7:4] == 4'd0);
            stop_cycles = 0;
            build_list();
          end
          default: ;
        endcase
      end
      prev_req = vram_req_tgl;
      prev_ack = vram_ack_tgl;
      prev_reg_ack = reg_wr_ack;
      prev_ce = ce;
      prev_rst = 1'b0;
    end
  end

endmodule

//--- bench/vdp_command_tb.sv
// Testbench for the bitmap command engine with a VRAM model and six directed tests

`timescale 1ns/1ps

module vdp_command_tb import vdp_cmd_pkg::*; ();

  // Rough pixel total of all tests and worst cycles per pixel
  localparam int PIXELS = 1200;
  localparam int CYCLES_PER_PIXEL = 48;
  localparam int WATCHDOG_CYCLES = PIXELS * CYCLES_PER_PIXEL + 20000;

  logic         clk;
  logic         reset;
  screen_mode_t mode;
  logic         reg_wr_req;
  reg_num_t     reg_num;
  color_t       reg_data;
  logic         vram_ack_tgl;
  color_t       vram_rdata;
  logic         reg_wr_ack;
  vram_req_t    vram_req;
  logic         vram_req_tgl;
  logic         ce;
  color_t       clr;
  int           errors;
  int           checks;
  int           tb_errors;
  int           last_errors;
  int           delay_mask;
  logic [31:0]  rng;
  color_t       mem [0:131071];

  vdp_command u_vdp_command (
    .clk(clk), .reset(reset), .mode(mode), .reg_wr_req(reg_wr_req), .reg_num(reg_num),
    .reg_data(reg_data), .vram_ack_tgl(vram_ack_tgl), .vram_rdata(vram_rdata),
    .reg_wr_ack(reg_wr_ack), .vram_req(vram_req), .vram_req_tgl(vram_req_tgl),
    .ce(ce), .clr(clr)
  );

  vdp_command_checker u_checker (
    .clk(clk), .reset(reset), .mode(mode), .reg_wr_ack(reg_wr_ack), .reg_num(reg_num),
    .reg_data(reg_data), .vram_req(vram_req), .vram_req_tgl(vram_req_tgl),
    .vram_ack_tgl(vram_ack_tgl), .vram_rdata(vram_rdata), .ce(ce), .clr(clr),
    .errors(errors), .checks(checks)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // VRAM model with random fill and random answer delay
  initial begin
    logic busy;
    int   wait_cnt;
    busy = 1'b0;
    wait_cnt = 0;
    vram_ack_tgl = 1'b0;
    vram_rdata = '0;
    rng = 32'd28;
    for (int a = 0; a < 131072; a++) begin
      rng = xorshift(rng);
      mem[a] = rng[7:0];
    end
    forever begin
      @(posedge clk);
      if (busy) begin
        if (wait_cnt == 0) begin
          if (vram_req.we) mem[vram_req.addr] = vram_req.wdata;
          else vram_rdata <= mem[vram_req.addr];
          vram_ack_tgl <= ~vram_ack_tgl;
          busy = 1'b0;
        end else begin
          wait_cnt--;
        end
      end else if (!reset && vram_req_tgl != vram_ack_tgl) begin
        busy = 1'b1;
        rng = xorshift(rng);
        wait_cnt = int'(rng[3:0]) & delay_mask;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic write_reg(input reg_num_t num, input color_t data);
    int n;
    @(posedge clk);
    reg_num <= num;
    reg_data <= data;
    reg_wr_req <= ~reg_wr_req;
    n = 0;
    @(posedge clk);
    while (reg_wr_ack != reg_wr_req && n < 8) begin
      @(posedge clk);
      n++;
    end
    if (reg_wr_ack != reg_wr_req) begin
      $display("register write %0d was never acknowledged", num);
      tb_errors++;
    end
  endtask

  task automatic set_rect(input coord_t dx, input coord_t dy, input coord_t nx,
                          input coord_t ny, input color_t arg);
    write_reg(4'd4, dx[7:0]);
    write_reg(4'd5, {6'd0, dx[9:8]});
    write_reg(4'd6, dy[7:0]);
    write_reg(4'd7, {6'd0, dy[9:8]});
    write_reg(4'd8, nx[7:0]);
    write_reg(4'd9, {6'd0, nx[9:8]});
    write_reg(4'd10, ny[7:0]);
    write_reg(4'd11, {6'd0, ny[9:8]});
    write_reg(4'd13, arg);
  endtask

  // Wait for ce to rise and then fall again
  task automatic wait_idle();
    int n;
    n = 0;
    while (!ce && n < 8) begin
      @(posedge clk);
      n++;
    end
    if (!ce) begin
      $display("command did not start");
      tb_errors++;
    end
    n = 0;
    while (ce && n < 20000) begin
      @(posedge clk);
      n++;
    end
    if (ce) begin
      $display("command did not finish");
      tb_errors++;
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic run_cmd(input color_t cmr);
    write_reg(4'd14, cmr);
    wait_idle();
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors + tb_errors - last_errors);
    last_errors = errors + tb_errors;
  endtask

  task automatic lmmv_case(input int m, input int lop, input int t);
    mode <= screen_mode_t'(m[0]);
    // Zero colour exercises the transparent path
    write_reg(4'd12, (t == 1 && lop[0] == 1'b0) ? 8'h00 : color_t'(lop * 37 + 91));
    set_rect(coord_t'(16 + lop * 9), coord_t'(30 + t * 4 + m * 10), 10'd5, 10'd2, 8'h00);
    run_cmd(color_t'(8'h80 | (t << 3) | lop));
  endtask

  initial begin
    reset = 1'b1;
    mode = MODE_G7;
    reg_wr_req = 1'b0;
    reg_num = '0;
    reg_data = '0;
    tb_errors = 0;
    last_errors = 0;
    delay_mask = 3;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    write_reg(4'd12, 8'h11);
    end_test(1, "reset and register handshake");

    for (int m = 0; m < 2; m++) begin
      for (int d = 0; d < 4; d++) begin
        mode <= screen_mode_t'(m[0]);
        write_reg(4'd12, color_t'(8'h30 + d));
        set_rect(10'd120, 10'd40, 10'd12, 10'd3, {4'd0, d[1:0], 2'd0});
        run_cmd(8'hc0);
      end
    end
    mode <= MODE_G7;
    set_rect(10'd250, 10'd60, 10'd20, 10'd2, 8'h00);
    run_cmd(8'hc0);
    set_rect(10'd200, 10'd1, 10'd4, 10'd5, 8'h08);
    run_cmd(8'hc0);
    end_test(2, "HMMV rectangles");

    for (int m = 0; m < 2; m++) begin
      for (int lop = 0; lop < 5; lop++) begin
        for (int t = 0; t < 2; t++) lmmv_case(m, lop, t);
      end
    end
    end_test(3, "LMMV logical operations");

    for (int m = 0; m < 2; m++) begin
      mode <= screen_mode_t'(m[0]);
      write_reg(4'd12, 8'ha5);
      set_rect(10'd77, 10'd33, 10'd1, 10'd1, 8'h00);
      run_cmd(8'h53);
      write_reg(4'd0, 8'd77);
      write_reg(4'd1, 8'd0);
      write_reg(4'd2, 8'd33);
      write_reg(4'd3, 8'd0);
      run_cmd(8'h40);
    end
    end_test(4, "PSET and POINT");

    mode <= MODE_G7;
    write_reg(4'd12, 8'he7);
    set_rect(10'd0, 10'd100, 10'd200, 10'd100, 8'h00);
    write_reg(4'd14, 8'hc0);
    repeat (60) @(posedge clk);
    write_reg(4'd14, 8'h00);
    wait_idle();
    repeat (20) @(posedge clk);
    end_test(5, "abort with STOP");

    delay_mask = 15;
    mode <= MODE_G4;
    write_reg(4'd12, 8'h5c);
    set_rect(10'd9, 10'd70, 10'd10, 10'd3, 8'h0c);
    run_cmd(8'hc0);
    lmmv_case(1, 3, 1);
    lmmv_case(0, 2, 0);
    end_test(6, "back-pressure");

    $display("checks %0d, errors %0d", checks, errors + tb_errors);
    if (errors == 0 && tb_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
src/vdp_cmd_pkg.sv
src/vdp_cmd_regs.sv
src/vdp_pixel_unit.sv
src/vdp_cmd_sequencer.sv
src/vdp_command.sv
bench/vdp_command_checker.sv
bench/vdp_command_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = vdp_command_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
